//--- ex_stage.f
+incdir+include
hw/ex_isa_pkg.sv
hw/ex_bus_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_result.sv
hw/ex_stage.sv
tests/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/ex_isa_pkg.sv
      - hw/ex_bus_pkg.sv
      - hw/ex_decode.sv
      - hw/ex_alu.sv
      - hw/ex_result.sv
      - hw/ex_stage.sv
      - target: test
        files:
          - tests/ex_stage_tb.sv

//--- tests/ex_stage_tb.sv
// ------------------------------------------------------------
// testbench for the execute stage
// clock and reset, stimulus table with expected values,
// reference model for ALU, compare and commit, output checks
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

module ex_stage_tb
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STALL_LIMIT = 20;

    // one table row: stimulus plus expected outputs
    typedef struct packed {
        ex_ctrl_t            ctrl;
        alu_req_t            alu;
        logic [3:0]          hold;
        wb_t                 wb;
        lsq_req_t            lsq;
        logic                jump;
        logic [`EX_XLEN-1:0] jump_addr;
        logic                cncl;
        logic                misalign;
        logic                stall;
    } entry_t;

    logic                clk;
    logic                reset_i;
    ex_ctrl_t            ctrl_i;
    alu_req_t            alu_i;
    logic                lsq_full_i;
    logic                ids_stall_o;
    wb_t                 wb_o;
    lsq_req_t            lsq_o;
    logic                cncl_load_o;
    logic                misalign_o;
    logic                jump_o;
    logic [`EX_XLEN-1:0] jump_addr_o;

    entry_t   stim[$];
    integer   seed;
    int       errors;
    int       timeouts;
    int       applied;
    int       idx;
    int       c;
    int       late;
    lsq_req_t held_lsq;

    ex_stage DUT (
        .clk_i       (clk),
        .reset_i     (reset_i),
        .ctrl_i      (ctrl_i),
        .alu_i       (alu_i),
        .lsq_full_i  (lsq_full_i),
        .ids_stall_o (ids_stall_o),
        .wb_o        (wb_o),
        .lsq_o       (lsq_o),
        .cncl_load_o (cncl_load_o),
        .misalign_o  (misalign_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr_o)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [`EX_XLEN-1:0] alu_model(alu_op_e op, logic [`EX_XLEN-1:0] a,
                                                      logic [`EX_XLEN-1:0] b);
        int unsigned sh;
        sh = b % 32;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return $unsigned($signed(a) >>> sh);
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            default:  return '0;
        endcase
    endfunction

    function automatic logic cmp_model(funct3_t f3, logic [`EX_XLEN-1:0] a,
                                       logic [`EX_XLEN-1:0] b);
        case (f3)
            f3_eq:   return a == b;
            f3_ne:   return a != b;
            f3_lt:   return $signed(a) < $signed(b);
            f3_ge:   return !($signed(a) < $signed(b));
            f3_ltu:  return a < b;
            f3_geu:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // off >= 0 forces an access address with that low offset
    task automatic add_entry(input zone_e zone, input alu_op_e op, input funct3_t f3,
                             input logic cond, input logic link, input logic jump,
                             input int off, input logic same, input int hold);
        entry_t              e;
        logic [`EX_XLEN-1:0] rnd;
        logic [`EX_XLEN-1:0] res;
        logic                access;
        logic                mis;
        logic                exec_ok;
        logic                commit;
        e = '0;
        rnd = $random(seed);
        e.ctrl.valid      = 1'b1;
        e.ctrl.zone       = zone;
        e.ctrl.cond       = cond;
        e.ctrl.link       = link;
        e.ctrl.jump       = jump;
        e.ctrl.ins_size   = rnd[1:0];
        e.ctrl.funct3     = f3;
        e.ctrl.regd_addr  = rnd[8:4];
        e.ctrl.pc         = $random(seed) & 32'hffff_fffe;
        e.ctrl.regs2_data = $random(seed);
        e.alu.op          = op;
        e.alu.left        = $random(seed);
        e.alu.right       = $random(seed);
        if (off >= 0) begin
            e.alu.left[1:0] = 2'b00;
            e.alu.right     = off;
        end
        e.alu.cmp_left  = $random(seed);
        e.alu.cmp_right = same ? e.alu.cmp_left : $random(seed);
        e.hold          = hold;

        res     = alu_model(op, e.alu.left, e.alu.right);
        access  = (zone == zone_loadq) || (zone == zone_storeq);
        mis     = access && (((f3 == f3_half) && res[0]) ||
                             ((f3 == f3_word) && (res[1:0] != 2'b00)));
        exec_ok = !cond || cmp_model(f3, e.alu.cmp_left, e.alu.cmp_right);
        commit  = exec_ok && !mis;

        e.wb.wr         = commit && (zone == zone_regfile);
        e.wb.addr       = e.ctrl.regd_addr;
        e.wb.data       = link ? e.ctrl.pc + 32'(e.ctrl.ins_size) * 2 : res;
        e.lsq.lq_wr     = commit && (zone == zone_loadq);
        e.lsq.sq_wr     = commit && (zone == zone_storeq);
        e.lsq.funct3    = f3;
        e.lsq.regd_addr = e.ctrl.regd_addr;
        e.lsq.data      = e.ctrl.regs2_data;
        e.lsq.addr      = res;
        e.jump          = commit && jump;
        e.jump_addr     = res & ~(`EX_XLEN'(1));
        e.cncl          = (zone == zone_loadq) && !commit;
        e.misalign      = exec_ok && mis;
        e.stall         = commit && access && (hold != 0);
        stim.push_back(e);
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_strobes_low();
        check_val("wb_o.wr", wb_o.wr, 0);
        check_val("lsq_o.lq_wr", lsq_o.lq_wr, 0);
        check_val("lsq_o.sq_wr", lsq_o.sq_wr, 0);
        check_val("jump_o", jump_o, 0);
        check_val("cncl_load_o", cncl_load_o, 0);
        check_val("misalign_o", misalign_o, 0);
    endtask

    task automatic check_outputs(input entry_t e);
        check_val("ids_stall_o", ids_stall_o, 0);
        check_val("wb_o", wb_o, e.wb);
        check_val("lsq_o", lsq_o, e.lsq);
        check_val("jump_o", jump_o, e.jump);
        check_val("jump_addr_o", jump_addr_o, e.jump_addr);
        check_val("cncl_load_o", cncl_load_o, e.cncl);
        check_val("misalign_o", misalign_o, e.misalign);
    endtask

    // returns the number of extra cycles the stall lingered
    task automatic wait_unstall(output int waited);
        int n;
        n = 0;
        #2;
        while (ids_stall_o !== 1'b0) begin
            if (n == STALL_LIMIT) begin
                $display("timeout: ids_stall_o still high %0d cycles after lsq_full_i dropped",
                         n);
                timeouts++;
                break;
            end
            @(negedge clk);
            #2;
            n++;
        end
        waited = n;
    endtask

    initial begin
        seed       = 25748;
        errors     = 0;
        timeouts   = 0;
        applied    = 0;
        late       = 0;
        clk        = 1'b0;
        reset_i    = 1'b1;
        ctrl_i     = '0;
        alu_i      = '0;
        lsq_full_i = 1'b0;

        // register ops, then link and jumps
        add_entry(zone_regfile, alu_add,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_sub,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_and,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_or,   f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_xor,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_sll,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_srl,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_sra,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_slt,  f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_sltu, f3_eq, 0, 0, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_add,  f3_eq, 0, 1, 0, -1, 0, 0);
        add_entry(zone_regfile, alu_add,  f3_eq, 0, 1, 1, -1, 0, 0);
        // conditional branches, taken and not taken
        add_entry(zone_none, alu_add, f3_eq,  1, 0, 1, -1, 1, 0);
        add_entry(zone_none, alu_add, f3_ne,  1, 0, 1, -1, 1, 0);
        add_entry(zone_none, alu_add, f3_ltu, 1, 0, 1, -1, 0, 0);
        add_entry(zone_none, alu_add, f3_ge,  1, 0, 1, -1, 0, 0);
        add_entry(zone_none, alu_add, f3_geu, 1, 0, 1, -1, 1, 0);
        // loads and stores, aligned and misaligned
        add_entry(zone_loadq,  alu_add, f3_word, 0, 0, 0, 0, 0, 0);
        add_entry(zone_loadq,  alu_add, f3_half, 0, 0, 0, 1, 0, 0);
        add_entry(zone_loadq,  alu_add, 3'b000,  0, 0, 0, 3, 0, 0);
        add_entry(zone_storeq, alu_add, f3_word, 0, 0, 0, 2, 0, 0);
        add_entry(zone_storeq, alu_add, f3_half, 0, 0, 0, 2, 0, 0);
        // back-pressure from a full queue
        add_entry(zone_loadq,  alu_add, f3_word, 0, 0, 0, 0, 0, 3);
        add_entry(zone_regfile, alu_xor, f3_eq,  0, 0, 0, -1, 0, 0);
        add_entry(zone_storeq, alu_add, f3_word, 0, 0, 0, 0, 0, 2);
        add_entry(zone_loadq,  alu_add, f3_half, 0, 0, 0, 2, 0, 1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        #2;
        check_val("ids_stall_o", ids_stall_o, 0);
        check_strobes_low();

        for (idx = 0; idx < stim.size(); idx++) begin
            @(negedge clk);
            ctrl_i     = stim[idx].ctrl;
            alu_i      = stim[idx].alu;
            lsq_full_i = 1'b0;
            #2;
            // previous instruction must not fire again
            check_val("ids_stall_o", ids_stall_o, 0);
            check_strobes_low();

            @(negedge clk);
            ctrl_i     = '0;
            alu_i      = '0;
            lsq_full_i = (stim[idx].hold != 0);
            #2;
            if (stim[idx].hold != 0) begin
                held_lsq       = stim[idx].lsq;
                held_lsq.lq_wr = 1'b0;
                held_lsq.sq_wr = 1'b0;
                for (c = 0; c < stim[idx].hold; c++) begin
                    if (c != 0) begin
                        @(negedge clk);
                        #2;
                    end
                    check_val("ids_stall_o", ids_stall_o, stim[idx].stall);
                    check_val("lsq_o", lsq_o, held_lsq);
                    check_strobes_low();
                end
                @(negedge clk);
                lsq_full_i = 1'b0;
                wait_unstall(late);
                // the held instruction commits in the first cycle after the drop
                if (late != 0) begin
                    $display("held instruction committed %0d cycles late at %0t ns",
                             late, $time);
                    errors++;
                end
            end
            if (timeouts != 0) begin
                break;
            end
            check_outputs(stim[idx]);
            applied++;
        end

        $display("errors: %0d value mismatches, %0d timeouts, %0d of %0d entries applied",
                 errors, timeouts, applied, stim.size());
        if (errors == 0 && timeouts == 0 && applied == stim.size()) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- hw/ex_stage.sv
// ------------------------------------------------------------
// execute stage top level
// issue register, ALU and result logic
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

module ex_stage
    import ex_bus_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  ex_ctrl_t            ctrl_i,
    input  alu_req_t            alu_i,
    input  logic                lsq_full_i,
    output logic                ids_stall_o,
    output wb_t                 wb_o,
    output lsq_req_t            lsq_o,
    output logic                cncl_load_o,
    output logic                misalign_o,
    output logic                jump_o,
    output logic [`EX_XLEN-1:0] jump_addr_o
);

    logic                stall;
    logic                stage_en;
    ex_pipe_t            pipe;
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_cmp;

    // hold everything while the queue is full
    assign stage_en    = ~stall;
    assign ids_stall_o = stall;

    ex_decode i_ex_decode (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stage_en_i (stage_en),
        .ctrl_i     (ctrl_i),
        .pipe_o     (pipe)
    );

    // compare code shares the funct3 field
    ex_alu i_ex_alu (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .stage_en_i   (stage_en),
        .req_i        (alu_i),
        .cmp_funct3_i (ctrl_i.funct3),
        .result_o     (alu_result),
        .cmp_o        (alu_cmp)
    );

    ex_result i_ex_result (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pipe_i       (pipe),
        .alu_result_i (alu_result),
        .cmp_i        (alu_cmp),
        .lsq_full_i   (lsq_full_i),
        .stall_o      (stall),
        .wb_o         (wb_o),
        .lsq_o        (lsq_o),
        .cncl_load_o  (cncl_load_o),
        .misalign_o   (misalign_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

//--- hw/ex_result.sv
// ------------------------------------------------------------
// commit qualification and misaligned access check
// write-back, load/store queue request, jump, stall
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

module ex_result
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  ex_pipe_t            pipe_i,
    input  logic [`EX_XLEN-1:0] alu_result_i,
    input  logic                cmp_i,
    input  logic                lsq_full_i,
    output logic                stall_o,
    output wb_t                 wb_o,
    output lsq_req_t            lsq_o,
    output logic                cncl_load_o,
    output logic                misalign_o,
    output logic                jump_o,
    output logic [`EX_XLEN-1:0] jump_addr_o
);

    logic access;
    logic misaligned;
    logic exec;
    logic commit;
    logic stage_en;

    // ------------------------------------------------------------
    // qualification
    // ------------------------------------------------------------
    assign access = pipe_i.lq | pipe_i.sq;

    always_comb begin
        misaligned = 1'b0;
        if (pipe_i.funct3 == f3_half) begin
            misaligned = alu_result_i[0];
        end else if (pipe_i.funct3 == f3_word) begin
            misaligned = |alu_result_i[1:0];
        end
    end

    // branch taken or unconditional
    assign exec   = pipe_i.valid & (cmp_i | ~pipe_i.cond);
    assign commit = exec & ~(access & misaligned);

    // ------------------------------------------------------------
    // stall on a full queue
    // ------------------------------------------------------------
    assign stall_o  = commit & access & lsq_full_i;
    assign stage_en = ~stall_o;

    // ------------------------------------------------------------
    // strobes and payload
    // ------------------------------------------------------------
    assign wb_o.wr   = stage_en & commit & pipe_i.regd_wr;
    assign wb_o.addr = pipe_i.regd_addr;
    assign wb_o.data = pipe_i.link ? pipe_i.pc_inc : alu_result_i;

    assign lsq_o.lq_wr     = stage_en & commit & pipe_i.lq;
    assign lsq_o.sq_wr     = stage_en & commit & pipe_i.sq;
    assign lsq_o.funct3    = pipe_i.funct3;
    assign lsq_o.regd_addr = pipe_i.regd_addr;
    assign lsq_o.data      = pipe_i.regs2_data;
    assign lsq_o.addr      = alu_result_i;

    // load that will never write back its register
    assign cncl_load_o = stage_en & pipe_i.valid & pipe_i.lq & ~commit;
    assign misalign_o  = stage_en & exec & access & misaligned;

    assign jump_o      = stage_en & commit & pipe_i.jump;
    assign jump_addr_o = {alu_result_i[`EX_XLEN-1:1], 1'b0};

    // zone decode upstream keeps the queue strobes apart
    a_lq_sq_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(lsq_o.lq_wr && lsq_o.sq_wr));

    // held instruction stays put while the queue is full
    a_hold_in_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        stall_o |=> $stable(pipe_i) && $stable(alu_result_i) && $stable(cmp_i));

endmodule

//--- hw/ex_alu.sv
// ------------------------------------------------------------
// registered ALU and branch compare
// both outputs update on the stage enable
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

module ex_alu
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                stage_en_i,
    input  alu_req_t            req_i,
    input  funct3_t             cmp_funct3_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                cmp_o
);

    logic [`EX_XLEN-1:0] result_d;
    logic [`EX_XLEN-1:0] result_q;
    logic                cmp_d;
    logic                cmp_q;
    logic [4:0]          shamt;

    assign shamt = req_i.right[4:0];

    // ------------------------------------------------------------
    // arithmetic / logic
    // ------------------------------------------------------------
    always_comb begin
        case (req_i.op)
            alu_add:  result_d = req_i.left + req_i.right;
            alu_sub:  result_d = req_i.left - req_i.right;
            alu_and:  result_d = req_i.left & req_i.right;
            alu_or:   result_d = req_i.left | req_i.right;
            alu_xor:  result_d = req_i.left ^ req_i.right;
            alu_sll:  result_d = req_i.left << shamt;
            alu_srl:  result_d = req_i.left >> shamt;
            alu_sra:  result_d = $signed(req_i.left) >>> shamt;
            alu_slt:  result_d = {{(`EX_XLEN-1){1'b0}},
                                  $signed(req_i.left) < $signed(req_i.right)};
            alu_sltu: result_d = {{(`EX_XLEN-1){1'b0}}, req_i.left < req_i.right};
            default:  result_d = '0;
        endcase
    end

    // ------------------------------------------------------------
    // branch compare
    // ------------------------------------------------------------
    always_comb begin
        case (cmp_funct3_i)
            f3_eq:   cmp_d = (req_i.cmp_left == req_i.cmp_right);
            f3_ne:   cmp_d = (req_i.cmp_left != req_i.cmp_right);
            f3_lt:   cmp_d = ($signed(req_i.cmp_left) <  $signed(req_i.cmp_right));
            f3_ge:   cmp_d = ($signed(req_i.cmp_left) >= $signed(req_i.cmp_right));
            f3_ltu:  cmp_d = (req_i.cmp_left <  req_i.cmp_right);
            f3_geu:  cmp_d = (req_i.cmp_left >= req_i.cmp_right);
            default: cmp_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_q <= 1'b0;
        end else if (stage_en_i) begin
            cmp_q <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;
    assign cmp_o    = cmp_q;

    // decode never issues an undefined operation
    a_op_defined: assert property (@(posedge clk_i) disable iff (reset_i)
        stage_en_i |-> req_i.op inside {[alu_add:alu_sltu]});

endmodule

//--- hw/ex_decode.sv
// ------------------------------------------------------------
// issue delay register
// zone decode to one-hot flags, link address precompute
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

module ex_decode
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     stage_en_i,
    input  ex_ctrl_t ctrl_i,
    output ex_pipe_t pipe_o
);

    ex_pipe_t pipe_q;

    assign pipe_o = pipe_q;

    // ------------------------------------------------------------
    // control flags
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pipe_q.valid   <= 1'b0;
            pipe_q.lq      <= 1'b0;
            pipe_q.sq      <= 1'b0;
            pipe_q.regd_wr <= 1'b0;
            pipe_q.cond    <= 1'b0;
            pipe_q.link    <= 1'b0;
            pipe_q.jump    <= 1'b0;
        end else if (stage_en_i) begin
            pipe_q.valid   <= ctrl_i.valid;
            // zone decode
            pipe_q.lq      <= (ctrl_i.zone == zone_loadq);
            pipe_q.sq      <= (ctrl_i.zone == zone_storeq);
            pipe_q.regd_wr <= (ctrl_i.zone == zone_regfile);
            pipe_q.cond    <= ctrl_i.cond;
            pipe_q.link    <= ctrl_i.link;
            pipe_q.jump    <= ctrl_i.jump;
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            pipe_q.funct3     <= ctrl_i.funct3;
            pipe_q.regd_addr  <= ctrl_i.regd_addr;
            pipe_q.regs2_data <= ctrl_i.regs2_data;
            // link value, ins_size counts half-words
            pipe_q.pc_inc     <= ctrl_i.pc
                + {{(`EX_XLEN-`EX_INS_SIZE_W-1){1'b0}}, ctrl_i.ins_size, 1'b0};
        end
    end

    // one destination per held instruction
    a_zone_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({pipe_q.lq, pipe_q.sq, pipe_q.regd_wr}));

endmodule

//--- hw/ex_bus_pkg.sv
// ------------------------------------------------------------
// structs carried between decode, execute and the outside
// control word, ALU request, held pipe state,
// write-back and load/store queue request
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

package ex_bus_pkg;

    import ex_isa_pkg::*;

    // issued control word from the decode stage
    typedef struct packed {
        logic                  valid;
        zone_e                 zone;
        logic                  cond;
        logic                  link;
        logic                  jump;
        ins_size_t             ins_size;
        funct3_t               funct3;
        logic [`EX_REGA_W-1:0] regd_addr;
        logic [`EX_XLEN-1:0]   pc;
        logic [`EX_XLEN-1:0]   regs2_data;
    } ex_ctrl_t;

    // operands for the ALU and the branch compare
    typedef struct packed {
        alu_op_e             op;
        logic [`EX_XLEN-1:0] left;
        logic [`EX_XLEN-1:0] right;
        logic [`EX_XLEN-1:0] cmp_left;
        logic [`EX_XLEN-1:0] cmp_right;
    } alu_req_t;

    // held instruction, zone already one-hot
    typedef struct packed {
        logic                  valid;
        logic                  lq;
        logic                  sq;
        logic                  regd_wr;
        logic                  cond;
        logic                  link;
        logic                  jump;
        funct3_t               funct3;
        logic [`EX_REGA_W-1:0] regd_addr;
        logic [`EX_XLEN-1:0]   pc_inc;
        logic [`EX_XLEN-1:0]   regs2_data;
    } ex_pipe_t;

    typedef struct packed {
        logic                  wr;
        logic [`EX_REGA_W-1:0] addr;
        logic [`EX_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic                  lq_wr;
        logic                  sq_wr;
        funct3_t               funct3;
        logic [`EX_REGA_W-1:0] regd_addr;
        logic [`EX_XLEN-1:0]   data;
        logic [`EX_XLEN-1:0]   addr;
    } lsq_req_t;

endpackage

//--- hw/ex_isa_pkg.sv
// ------------------------------------------------------------
// ISA level types for the execute stage
// ALU operations, zones, funct3 codes, instruction size
// ------------------------------------------------------------

`include "ex_stage_cfg.svh"

package ex_isa_pkg;

    // ALU operation select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    // where the result of an instruction goes
    typedef enum logic [1:0] {
        zone_none    = 2'd0,
        zone_regfile = 2'd1,
        zone_loadq   = 2'd2,
        zone_storeq  = 2'd3
    } zone_e;

    typedef logic [`EX_FUNCT3_W-1:0]   funct3_t;
    typedef logic [`EX_INS_SIZE_W-1:0] ins_size_t;

    // branch compare codes
    localparam funct3_t f3_eq  = 3'b000;
    localparam funct3_t f3_ne  = 3'b001;
    localparam funct3_t f3_lt  = 3'b100;
    localparam funct3_t f3_ge  = 3'b101;
    localparam funct3_t f3_ltu = 3'b110;
    localparam funct3_t f3_geu = 3'b111;

    // access sizes, byte is 3'b000 and never misaligned
    localparam funct3_t f3_half = 3'b001;
    localparam funct3_t f3_word = 3'b010;

endpackage

//--- include/ex_stage_cfg.svh
// ------------------------------------------------------------
// execute stage configuration macros
// data width, register address width and field widths
// ------------------------------------------------------------

`ifndef EX_STAGE_CFG_SVH
`define EX_STAGE_CFG_SVH

// data and address width
`define EX_XLEN 32

// register file address
`define EX_REGA_W 5

// size fields
`define EX_FUNCT3_W 3
`define EX_INS_SIZE_W 2

`endif
